//--- design/motor_regs_defines.svh
// Address map, channel counts and field widths of the motor register block
// Included by the package, the RTL and the testbench
`ifndef MOTOR_REGS_DEFINES_SVH
`define MOTOR_REGS_DEFINES_SVH

`define ADDR_W          6       // Host address width
`define DATA_W          8       // Register width
`define NUM_CH          4       // Channels per bank
`define ANGLE_W         12      // Rotation angle width
`define TEMP_W          6       // Temperature bits kept in status
`define PWM_W           5       // Drive PWM width

// Broadcast writes to control registers
`define BCAST_ALL       6'h01   // Every control register
`define BCAST_ROT       6'h02   // Rotation control only
`define BCAST_DRIVE     6'h03   // Drive control only

`define DRIVE_BASE      6'h04   // Control at base+2n, status at base+2n+1
`define ROT_BASE        6'h0C   // Five registers per rotation channel
`define ROT_STRIDE      5

`define CMD_ABORT_BIT   4       // Command bits in current-high writes
`define CMD_UPDATE_BIT  5

`endif

//--- design/motor_regs_pkg.sv
// Register layouts shared by the decoder and both channel banks
// Import inside a module body where a type is needed
`default_nettype none

`include "motor_regs_defines.svh"

package motor_regs_pkg;

    typedef struct packed {
        logic               brake;
        logic               enable;
        logic               direction;
        logic [`PWM_W-1:0]  pwm;        // Duty cycle
    } drive_ctrl_t;

    typedef struct packed {
        logic                       brake;
        logic                       enable;
        logic                       direction;
        logic                       rsvd;   // Unused, stored as written
        logic [`ANGLE_W-`DATA_W-1:0] target_hi;
    } rot_ctrl_t;

    // Same stored byte, seen through whichever bank owns it
    typedef union packed {
        drive_ctrl_t drive;
        rot_ctrl_t   rot;
    } ctrl_word_u;

    typedef struct packed {
        logic               fault;
        logic               startup_fail;
        logic [`TEMP_W-1:0] temp;       // ADC bit 6 not kept
    } status_t;

    // Register slot within one channel, in address order
    typedef enum logic [2:0] {
        CONTROL, STATUS, TARGET_LO, CURRENT_LO, CURRENT_HI
    } ch_field_e;

    typedef logic [1:0] ch_idx_t;

endpackage

`default_nettype wire

//--- design/reg_bus_if.sv
// Write and read path from the address decoder to one channel bank
// The decoder resolves the address, the bank only sees channel and field
`timescale 1ns/10ps
`default_nettype none

`include "motor_regs_defines.svh"

interface reg_bus_if;
    import motor_regs_pkg::*;

    logic               wr_stb;     // One-cycle write
    logic               bcast;      // Write control field of every channel
    ch_idx_t            ch;
    ch_field_e          field;
    logic [`DATA_W-1:0] wr_data;
    logic [`DATA_W-1:0] rd_word;    // Combinational, follows ch and field

    modport decoder (output wr_stb, bcast, ch, field, wr_data, input rd_word);

    modport bank (input wr_stb, bcast, ch, field, wr_data, output rd_word);

endinterface

`default_nettype wire

//--- design/addr_decoder.sv
// Host address decoder for the motor register block
// Maps each address to a bank, channel and field, and registers read data
`timescale 1ns/10ps
`default_nettype none

`include "motor_regs_defines.svh"

module addr_decoder (
    input  wire logic               clock,
    input  wire logic               arst_n,
    input  wire logic [`ADDR_W-1:0] address,
    input  wire logic               write_en,
    input  wire logic               read_en,
    input  wire logic [`DATA_W-1:0] wr_data,
    output logic      [`DATA_W-1:0] rd_data,
    reg_bus_if.decoder              drive_bus,
    reg_bus_if.decoder              rot_bus
);
    import motor_regs_pkg::*;

    // First address past each bank
    localparam logic [`ADDR_W-1:0] DRIVE_END = `ADDR_W'(`DRIVE_BASE + 2 * `NUM_CH);
    localparam logic [`ADDR_W-1:0] ROT_END   = `ADDR_W'(`ROT_BASE + `ROT_STRIDE * `NUM_CH);

    logic [`ADDR_W-1:0] drive_off;
    logic [`ADDR_W-1:0] rot_off;
    logic               drive_hit, rot_hit;
    logic               drive_bcast, rot_bcast;
    ch_idx_t            drive_ch, rot_ch;
    ch_field_e          drive_fld, rot_fld;

    always_comb begin
        drive_off = address - `DRIVE_BASE;
        rot_off   = address - `ROT_BASE;
        drive_hit = (address >= `DRIVE_BASE) && (address < DRIVE_END);
        rot_hit   = (address >= `ROT_BASE) && (address < ROT_END);
        drive_ch  = ch_idx_t'(drive_off[2:1]);          // Two addresses per channel
        drive_fld = drive_off[0] ? STATUS : CONTROL;
        // Last stride boundary passed picks the channel
        rot_ch  = '0;
        rot_fld = CONTROL;
        for (int n = 0; n < `NUM_CH; n++) begin
            if (rot_off >= `ADDR_W'(n * `ROT_STRIDE)) begin
                rot_ch  = ch_idx_t'(n);
                rot_fld = ch_field_e'(3'(rot_off - `ADDR_W'(n * `ROT_STRIDE)));
            end
        end
        drive_bcast = (address == `BCAST_ALL) || (address == `BCAST_DRIVE);
        rot_bcast   = (address == `BCAST_ALL) || (address == `BCAST_ROT);
    end

    assign drive_bus.wr_stb  = write_en && (drive_hit || drive_bcast);
    assign drive_bus.bcast   = drive_bcast;
    assign drive_bus.ch      = drive_ch;
    assign drive_bus.field   = drive_fld;
    assign drive_bus.wr_data = wr_data;

    assign rot_bus.wr_stb  = write_en && (rot_hit || rot_bcast);
    assign rot_bus.bcast   = rot_bcast;
    assign rot_bus.ch      = rot_ch;
    assign rot_bus.field   = rot_fld;
    assign rot_bus.wr_data = wr_data;

    // Read data holds until the next read
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rd_data <= '0;
        end else if (read_en) begin
            if (drive_hit) begin
                rd_data <= drive_bus.rd_word;
            end else if (rot_hit) begin
                rd_data <= rot_bus.rd_word;
            end else begin
                rd_data <= '0;                          // Broadcast and unmapped read zero
            end
        end
    end

    // Only the all-channel broadcast may write both banks at once
    a_dual_strobe: assert property (@(posedge clock) disable iff (!arst_n)
        drive_bus.wr_stb && rot_bus.wr_stb |-> address == `BCAST_ALL);

endmodule

`default_nettype wire

//--- design/drive_channels.sv
// Drive-motor bank, four control words and four captured status bytes
// Control fields go straight out to the motor drivers
`timescale 1ns/10ps
`default_nettype none

`include "motor_regs_defines.svh"

module drive_channels (
    input  wire logic                             clock,
    input  wire logic                             arst_n,
    reg_bus_if.bank                               bus,
    input  wire logic [`NUM_CH-1:0]               fault,
    input  wire logic [`NUM_CH-1:0]               startup_fail,
    input  wire logic [`NUM_CH-1:0][`TEMP_W:0]    temp,       // Top bit dropped
    output logic      [`NUM_CH-1:0]               brake,
    output logic      [`NUM_CH-1:0]               enable,
    output logic      [`NUM_CH-1:0]               direction,
    output logic      [`NUM_CH-1:0][`PWM_W-1:0]   pwm
);
    import motor_regs_pkg::*;

    ctrl_word_u ctrl_q   [`NUM_CH];
    status_t    status_q [`NUM_CH];

    // Control writes, addressed or broadcast
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int n = 0; n < `NUM_CH; n++) begin
                ctrl_q[n] <= '0;
            end
        end else if (bus.wr_stb) begin
            for (int n = 0; n < `NUM_CH; n++) begin
                if (bus.bcast || (bus.field == CONTROL && bus.ch == ch_idx_t'(n))) begin
                    ctrl_q[n] <= bus.wr_data;
                end
            end
        end
    end

    // Status sampled every cycle
    always_ff @(posedge clock) begin
        for (int n = 0; n < `NUM_CH; n++) begin
            status_q[n] <= {fault[n], startup_fail[n], temp[n][`TEMP_W-1:0]};
        end
    end

    always_comb begin
        for (int n = 0; n < `NUM_CH; n++) begin
            brake[n]     = ctrl_q[n].drive.brake;
            enable[n]    = ctrl_q[n].drive.enable;
            direction[n] = ctrl_q[n].drive.direction;
            pwm[n]       = ctrl_q[n].drive.pwm;
        end
    end

    // Drive channels own only two slots
    always_comb begin
        case (bus.field)
            CONTROL: bus.rd_word = ctrl_q[bus.ch];
            STATUS:  bus.rd_word = status_q[bus.ch];
            default: bus.rd_word = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/rotation_channels.sv
// Rotation-motor bank with control, target angle, angle readback and command pulses
// Commands are write-only bits of the current-high slot
`timescale 1ns/10ps
`default_nettype none

`include "motor_regs_defines.svh"

module rotation_channels (
    input  wire logic                              clock,
    input  wire logic                              arst_n,
    reg_bus_if.bank                                bus,
    input  wire logic [`NUM_CH-1:0]                fault,
    input  wire logic [`NUM_CH-1:0]                startup_fail,
    input  wire logic [`NUM_CH-1:0][`TEMP_W:0]     temp,       // Top bit dropped
    input  wire logic [`NUM_CH-1:0][`ANGLE_W-1:0]  current_angle,
    input  wire logic [`NUM_CH-1:0]                angle_done,
    output logic      [`NUM_CH-1:0]                brake,
    output logic      [`NUM_CH-1:0]                enable,
    output logic      [`NUM_CH-1:0]                direction,
    output logic      [`NUM_CH-1:0][`ANGLE_W-1:0]  target_angle,
    output logic      [`NUM_CH-1:0]                update,
    output logic      [`NUM_CH-1:0]                abort
);
    import motor_regs_pkg::*;

    ctrl_word_u         ctrl_q   [`NUM_CH];
    logic [`DATA_W-1:0] tgt_lo_q [`NUM_CH];
    status_t            status_q [`NUM_CH];
    logic [`ANGLE_W-1:0] cur_q   [`NUM_CH];
    logic [`NUM_CH-1:0] done_q;
    logic [`NUM_CH-1:0] cmd_wr;         // Addressed write to current-high

    always_comb begin
        for (int n = 0; n < `NUM_CH; n++) begin
            cmd_wr[n] = bus.wr_stb && !bus.bcast && bus.field == CURRENT_HI
                        && bus.ch == ch_idx_t'(n);
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int n = 0; n < `NUM_CH; n++) begin
                ctrl_q[n]   <= '0;
                tgt_lo_q[n] <= '0;
            end
            update <= '0;
            abort  <= '0;
        end else begin
            for (int n = 0; n < `NUM_CH; n++) begin
                if (bus.wr_stb && (bus.bcast
                        || (bus.field == CONTROL && bus.ch == ch_idx_t'(n)))) begin
                    ctrl_q[n] <= bus.wr_data;
                end
                if (bus.wr_stb && !bus.bcast && bus.field == TARGET_LO
                        && bus.ch == ch_idx_t'(n)) begin
                    tgt_lo_q[n] <= bus.wr_data;
                end
                // Pulses last one cycle unless written again
                update[n] <= cmd_wr[n] && bus.wr_data[`CMD_UPDATE_BIT];
                abort[n]  <= cmd_wr[n] && bus.wr_data[`CMD_ABORT_BIT];
            end
        end
    end

    // Motor feedback sampled every cycle
    always_ff @(posedge clock) begin
        for (int n = 0; n < `NUM_CH; n++) begin
            status_q[n] <= {fault[n], startup_fail[n], temp[n][`TEMP_W-1:0]};
            cur_q[n]    <= current_angle[n];
            done_q[n]   <= angle_done[n];
        end
    end

    always_comb begin
        for (int n = 0; n < `NUM_CH; n++) begin
            brake[n]        = ctrl_q[n].rot.brake;
            enable[n]       = ctrl_q[n].rot.enable;
            direction[n]    = ctrl_q[n].rot.direction;
            target_angle[n] = {ctrl_q[n].rot.target_hi, tgt_lo_q[n]};  // Upper nibble in control
        end
    end

    always_comb begin
        case (bus.field)
            CONTROL:    bus.rd_word = ctrl_q[bus.ch];
            STATUS:     bus.rd_word = status_q[bus.ch];
            TARGET_LO:  bus.rd_word = tgt_lo_q[bus.ch];
            CURRENT_LO: bus.rd_word = cur_q[bus.ch][`DATA_W-1:0];
            CURRENT_HI: bus.rd_word = {done_q[bus.ch], 3'b000,
                                       cur_q[bus.ch][`ANGLE_W-1:`DATA_W]};
            default:    bus.rd_word = '0;
        endcase
    end

    // A second pulse cycle needs a current-high write in each of the two cycles before
    for (genvar n = 0; n < `NUM_CH; n++) begin : g_pulse_chk
        a_update_single: assert property (@(posedge clock) disable iff (!arst_n)
            update[n] && $past(update[n]) |->
                $past(bus.wr_stb && bus.field == CURRENT_HI, 1)
                && $past(bus.wr_stb && bus.field == CURRENT_HI, 2));
        a_abort_single: assert property (@(posedge clock) disable iff (!arst_n)
            abort[n] && $past(abort[n]) |->
                $past(bus.wr_stb && bus.field == CURRENT_HI, 1)
                && $past(bus.wr_stb && bus.field == CURRENT_HI, 2));
    end

endmodule

`default_nettype wire

//--- design/motor_regs.sv
// Top level of the motor controller register block
// Host register port plus per-channel motor signals, wiring only
`timescale 1ns/10ps
`default_nettype none

`include "motor_regs_defines.svh"

module motor_regs (
    input  wire logic                              clock,
    input  wire logic                              arst_n,
    input  wire logic [`ADDR_W-1:0]                address,
    input  wire logic                              write_en,
    input  wire logic [`DATA_W-1:0]                wr_data,
    input  wire logic                              read_en,
    output logic      [`DATA_W-1:0]                rd_data,

    // Drive motors
    input  wire logic [`NUM_CH-1:0]                drive_fault,
    input  wire logic [`NUM_CH-1:0]                drive_startup_fail,
    input  wire logic [`NUM_CH-1:0][`TEMP_W:0]     drive_temp,        // ADC reading
    output logic      [`NUM_CH-1:0]                drive_brake,
    output logic      [`NUM_CH-1:0]                drive_enable,
    output logic      [`NUM_CH-1:0]                drive_direction,
    output logic      [`NUM_CH-1:0][`PWM_W-1:0]    drive_pwm,

    // Rotation motors
    input  wire logic [`NUM_CH-1:0]                rot_fault,
    input  wire logic [`NUM_CH-1:0]                rot_startup_fail,
    input  wire logic [`NUM_CH-1:0][`TEMP_W:0]     rot_temp,
    output logic      [`NUM_CH-1:0]                rot_brake,
    output logic      [`NUM_CH-1:0]                rot_enable,
    output logic      [`NUM_CH-1:0]                rot_direction,
    output logic      [`NUM_CH-1:0][`ANGLE_W-1:0]  rot_target_angle,
    input  wire logic [`NUM_CH-1:0][`ANGLE_W-1:0]  rot_current_angle, // From the encoder
    input  wire logic [`NUM_CH-1:0]                rot_angle_done,    // Arrived at target
    output logic      [`NUM_CH-1:0]                rot_update,        // Start move, one cycle
    output logic      [`NUM_CH-1:0]                rot_abort          // Stop move, one cycle
);

    reg_bus_if drive_bus ();
    reg_bus_if rot_bus ();

    addr_decoder addr_decoder_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .address    (address),
        .write_en   (write_en),
        .read_en    (read_en),
        .wr_data    (wr_data),
        .rd_data    (rd_data),
        .drive_bus  (drive_bus.decoder),
        .rot_bus    (rot_bus.decoder)
    );

    drive_channels drive_channels_i (
        .clock          (clock),
        .arst_n         (arst_n),
        .bus            (drive_bus.bank),
        .fault          (drive_fault),
        .startup_fail   (drive_startup_fail),
        .temp           (drive_temp),
        .brake          (drive_brake),
        .enable         (drive_enable),
        .direction      (drive_direction),
        .pwm            (drive_pwm)
    );

    rotation_channels rotation_channels_i (
        .clock          (clock),
        .arst_n         (arst_n),
        .bus            (rot_bus.bank),
        .fault          (rot_fault),
        .startup_fail   (rot_startup_fail),
        .temp           (rot_temp),
        .current_angle  (rot_current_angle),
        .angle_done     (rot_angle_done),
        .brake          (rot_brake),
        .enable         (rot_enable),
        .direction      (rot_direction),
        .target_angle   (rot_target_angle),
        .update         (rot_update),
        .abort          (rot_abort)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
// Free-running clock and power-on reset for the register block testbench
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;      // Release away from the rising edge
    end

endmodule

`default_nettype wire

//--- sim/motor_regs_tb.sv
// Testbench for the motor register block with random host traffic on a shadow model
// Inputs change on the falling edge where the compare process also checks
`timescale 1ns/10ps
`default_nettype none

`include "motor_regs_defines.svh"

module motor_regs_tb;
    localparam int WAIT_LIMIT = 8;      // Cycles allowed for reset or a strobe

    logic                              clock, arst_n;
    logic [`ADDR_W-1:0]                address;
    logic                              write_en, read_en;
    logic [`DATA_W-1:0]                wr_data, rd_data;
    logic [`NUM_CH-1:0]                drive_fault, drive_startup_fail;
    logic [`NUM_CH-1:0]                rot_fault, rot_startup_fail, rot_angle_done;
    logic [`NUM_CH-1:0][`TEMP_W:0]     drive_temp, rot_temp;
    logic [`NUM_CH-1:0]                drive_brake, drive_enable, drive_direction;
    logic [`NUM_CH-1:0][`PWM_W-1:0]    drive_pwm;
    logic [`NUM_CH-1:0]                rot_brake, rot_enable, rot_direction;
    logic [`NUM_CH-1:0]                rot_update, rot_abort;
    logic [`NUM_CH-1:0][`ANGLE_W-1:0]  rot_target_angle, rot_current_angle;

    // Shadow of the writable registers
    logic [`DATA_W-1:0] ctrl_sh [2*`NUM_CH];    // Drive 0-3, rotation 4-7
    logic [`DATA_W-1:0] tgt_sh  [`NUM_CH];
    logic [`DATA_W-1:0] exp_rd;
    logic [`NUM_CH-1:0] exp_update, exp_abort;
    logic [31:0]        lfsr;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) tb_clock_gen_i (
        .clock  (clock),
        .arst_n (arst_n)
    );

    motor_regs motor_regs_i (.*);

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_with_error("Mismatch against the register model");
        end
    endtask

    // Galois form with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int width, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < width; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[62:0], lfsr[0]};      // One step per bit
        end
    endtask

    // Expected read data from the shadow map and the live inputs
    function automatic logic [`DATA_W-1:0] ref_read(input logic [`ADDR_W-1:0] addr);
        int                  off, n;
        logic [`ANGLE_W-1:0] cur;
        ref_read = '0;                                  // Unmapped and broadcast
        if (addr >= `DRIVE_BASE && addr < `DRIVE_BASE + 2 * `NUM_CH) begin
            off = addr - `DRIVE_BASE;
            n   = off / 2;
            if (off % 2 == 0)
                ref_read = ctrl_sh[n];
            else
                ref_read = {drive_fault[n], drive_startup_fail[n], drive_temp[n][`TEMP_W-1:0]};
        end else if (addr >= `ROT_BASE && addr < `ROT_BASE + `ROT_STRIDE * `NUM_CH) begin
            off = addr - `ROT_BASE;
            n   = off / `ROT_STRIDE;
            cur = rot_current_angle[n];
            case (off % `ROT_STRIDE)
                0: ref_read = ctrl_sh[`NUM_CH+n];
                1: ref_read = {rot_fault[n], rot_startup_fail[n], rot_temp[n][`TEMP_W-1:0]};
                2: ref_read = tgt_sh[n];
                3: ref_read = cur[7:0];
                default: ref_read = {rot_angle_done[n], 3'b000, cur[11:8]};  // Done flag and top
            endcase
        end
    endfunction

    task automatic apply_write(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
        int off;
        off = addr - `ROT_BASE;
        for (int n = 0; n < `NUM_CH; n++) begin
            if (addr == `BCAST_ALL || addr == `BCAST_DRIVE) ctrl_sh[n] = data;
            if (addr == `BCAST_ALL || addr == `BCAST_ROT) ctrl_sh[`NUM_CH+n] = data;
        end
        if (addr >= `DRIVE_BASE && addr < `DRIVE_BASE + 2 * `NUM_CH
                && (addr - `DRIVE_BASE) % 2 == 0) begin
            ctrl_sh[(addr - `DRIVE_BASE) / 2] = data;  // Status slots read-only
        end
        if (addr >= `ROT_BASE && off < `ROT_STRIDE * `NUM_CH) begin
            case (off % `ROT_STRIDE)
                0: ctrl_sh[`NUM_CH + off / `ROT_STRIDE] = data;
                2: tgt_sh[off / `ROT_STRIDE] = data;
                4: begin                                // Command bits, nothing stored
                    exp_update[off / `ROT_STRIDE] = data[`CMD_UPDATE_BIT];
                    exp_abort[off / `ROT_STRIDE]  = data[`CMD_ABORT_BIT];
                end
                default: ;
            endcase
        end
    endtask

    // One host cycle between falling edges with the model updated at the rising edge
    task automatic bus_cycle(input logic we, input logic re, input logic [`ADDR_W-1:0] addr,
                             input logic [`DATA_W-1:0] data);
        write_en = we;
        read_en  = re;
        address  = addr;
        wr_data  = data;
        @(posedge clock);
        exp_update = '0;                                // Pulses last one cycle
        exp_abort  = '0;
        if (we) apply_write(addr, data);
        if (re) exp_rd = ref_read(addr);
        @(negedge clock);
        write_en = 1'b0;
        read_en  = 1'b0;
    endtask

    task automatic randomize_inputs;
        logic [63:0] r;
        rand_bits(20, r);
        {drive_fault, drive_startup_fail, rot_fault, rot_startup_fail, rot_angle_done} = r[19:0];
        for (int n = 0; n < `NUM_CH; n++) begin
            rand_bits(14, r);
            drive_temp[n] = r[6:0];                     // Bit 6 set half the time
            rot_temp[n]   = r[13:7];
            rand_bits(12, r);
            rot_current_angle[n] = r[11:0];
        end
    endtask

    task automatic wait_reset;
        int cnt;
        cnt = 0;
        while (arst_n !== 1'b1) begin
            if (cnt == WAIT_LIMIT) begin
                stop_with_error("Reset was never released");
            end else begin
                cnt++;
                @(negedge clock);
            end
        end
    endtask

    // Strobe must already be up on the falling edge after the command edge
    task automatic wait_strobe;
        int cnt;
        cnt = 0;
        while ((rot_update | rot_abort) == '0) begin
            if (cnt == WAIT_LIMIT) begin
                stop_with_error("No update or abort strobe after a command write");
            end else begin
                cnt++;
                bus_cycle(1'b0, 1'b0, '0, '0);
            end
        end
        check_value("strobe delay", cnt, 0);
    endtask

    // Compare process on the falling edge where registered outputs are stable
    always @(negedge clock) begin : compare
        logic [`NUM_CH-1:0]               brk, ena, dir, rbrk, rena, rdir;
        logic [`NUM_CH-1:0][`PWM_W-1:0]   pwm;
        logic [`NUM_CH-1:0][`ANGLE_W-1:0] tgt;
        if (arst_n) begin
            for (int n = 0; n < `NUM_CH; n++) begin
                {brk[n], ena[n], dir[n], pwm[n]} = ctrl_sh[n];          // Drive view
                {rbrk[n], rena[n], rdir[n]} = ctrl_sh[`NUM_CH+n][7:5];  // Rotation view
                tgt[n] = {ctrl_sh[`NUM_CH+n][3:0], tgt_sh[n]};
            end
            check_value("rd_data", rd_data, exp_rd);
            check_value("drive_brake", drive_brake, brk);
            check_value("drive_enable", drive_enable, ena);
            check_value("drive_direction", drive_direction, dir);
            check_value("drive_pwm", drive_pwm, pwm);
            check_value("rot_brake", rot_brake, rbrk);
            check_value("rot_enable", rot_enable, rena);
            check_value("rot_direction", rot_direction, rdir);
            check_value("rot_target_angle", rot_target_angle, tgt);
            check_value("rot_update", rot_update, exp_update);
            check_value("rot_abort", rot_abort, exp_abort);
        end
    end

    initial begin
        #1_000_000;
        stop_with_error("Simulation time limit reached");
    end

    initial begin
        logic [63:0]        r;
        logic [`ADDR_W-1:0] bc [3];
        {address, write_en, read_en, wr_data} = '0;
        {drive_fault, drive_startup_fail, drive_temp} = '0;
        {rot_fault, rot_startup_fail, rot_temp, rot_current_angle, rot_angle_done} = '0;
        {exp_rd, exp_update, exp_abort} = '0;
        lfsr   = 32'hac87;
        bc     = '{`BCAST_ALL, `BCAST_ROT, `BCAST_DRIVE};
        for (int n = 0; n < 2 * `NUM_CH; n++) ctrl_sh[n] = '0;
        for (int n = 0; n < `NUM_CH; n++) tgt_sh[n] = '0;
        wait_reset();

        // Reset values of every writable slot
        for (int n = 0; n < `NUM_CH; n++) begin
            bus_cycle(1'b0, 1'b1, `ADDR_W'(`DRIVE_BASE + 2 * n), '0);
            bus_cycle(1'b0, 1'b1, `ADDR_W'(`ROT_BASE + `ROT_STRIDE * n), '0);
            bus_cycle(1'b0, 1'b1, `ADDR_W'(`ROT_BASE + `ROT_STRIDE * n + 2), '0);
        end

        // Addressed writes with readback
        for (int n = 0; n < `NUM_CH; n++) begin
            for (int k = 0; k < 3; k++) begin
                rand_bits(8, r);
                bus_cycle(1'b1, 1'b0, `ADDR_W'(k == 0 ? `DRIVE_BASE + 2 * n
                          : `ROT_BASE + `ROT_STRIDE * n + 2 * (k - 1)), r[7:0]);
                bus_cycle(1'b0, 1'b1, address, '0);
            end
        end

        // Broadcasts over distinct per-channel values
        foreach (bc[b]) begin
            for (int n = 0; n < 2 * `NUM_CH; n++) begin
                rand_bits(8, r);
                bus_cycle(1'b1, 1'b0, `ADDR_W'(n < `NUM_CH ? `DRIVE_BASE + 2 * n
                          : `ROT_BASE + `ROT_STRIDE * (n - `NUM_CH)), r[7:0]);
            end
            rand_bits(8, r);
            bus_cycle(1'b1, 1'b0, bc[b], r[7:0]);
            bus_cycle(1'b0, 1'b1, bc[b], '0);           // Broadcast slot reads zero
            for (int n = 0; n < `NUM_CH; n++) begin
                bus_cycle(1'b0, 1'b1, `ADDR_W'(`DRIVE_BASE + 2 * n), '0);
                bus_cycle(1'b0, 1'b1, `ADDR_W'(`ROT_BASE + `ROT_STRIDE * n), '0);
            end
        end

        // Status and angle readback with inputs held
        repeat (4) begin
            randomize_inputs();
            bus_cycle(1'b0, 1'b0, '0, '0);              // Let the capture settle
            for (int n = 0; n < `NUM_CH; n++) begin
                bus_cycle(1'b0, 1'b1, `ADDR_W'(`DRIVE_BASE + 2 * n + 1), '0);
                for (int f = 1; f < `ROT_STRIDE; f++) begin
                    bus_cycle(1'b0, 1'b1, `ADDR_W'(`ROT_BASE + `ROT_STRIDE * n + f), '0);
                end
            end
        end

        // Command strobes for update, abort and both
        for (int n = 0; n < `NUM_CH; n++) begin
            for (int k = 1; k < 4; k++) begin
                rand_bits(8, r);
                bus_cycle(1'b1, 1'b0, `ADDR_W'(`ROT_BASE + `ROT_STRIDE * n + 4),
                          {r[7:6], 2'(k), r[3:0]});
                wait_strobe();
                bus_cycle(1'b0, 1'b0, '0, '0);
            end
        end

        // Unmapped addresses ignore writes and read zero
        repeat (8) begin
            rand_bits(14, r);
            bus_cycle(1'b1, 1'b0, r[13] ? {1'b1, r[12:8]} : '0, r[7:0]);
            bus_cycle(1'b0, 1'b1, address, '0);
        end
        bus_cycle(1'b0, 1'b0, '0, '0);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+design
design/motor_regs_pkg.sv
design/reg_bus_if.sv
design/addr_decoder.sv
design/drive_channels.sv
design/rotation_channels.sv
design/motor_regs.sv
sim/tb_clock_gen.sv
sim/motor_regs_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the register block testbench with Verilator, run it, judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module motor_regs_tb -o motor_regs_sim

# The run exits non-zero on a failure, the log decides the result
./obj_dir/motor_regs_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
